//--- source/id_pkg.sv
package id_pkg;

  // Datapath and register file sizes
  localparam int unsigned XLEN       = 32;
  localparam int unsigned REG_ADDR_W = 5;
  localparam int unsigned NUM_REGS   = 32;

  // PC step and second address of a misaligned access
  localparam logic [XLEN-1:0] ADDR_INCR = 32'd4;

  typedef enum logic [6:0] {
    OPCODE_OP     = 7'h33,
    OPCODE_OP_IMM = 7'h13,
    OPCODE_LUI    = 7'h37,
    OPCODE_AUIPC  = 7'h17,
    OPCODE_LOAD   = 7'h03,
    OPCODE_STORE  = 7'h23,
    OPCODE_BRANCH = 7'h63,
    OPCODE_JAL    = 7'h6f,
    OPCODE_JALR   = 7'h67
  } opcode_e;

  typedef enum logic [4:0] {
    ALU_ADD, ALU_SUB, ALU_XOR, ALU_OR, ALU_AND,
    ALU_SLL, ALU_SRL, ALU_SRA, ALU_SLT, ALU_SLTU,
    // Branch comparisons
    ALU_EQ, ALU_NE, ALU_LT, ALU_GE, ALU_LTU, ALU_GEU
  } alu_op_e;

  // OP_A_IMM feeds zero, used by LUI
  typedef enum logic [1:0] {
    OP_A_REG_A, OP_A_FWD, OP_A_CURRPC, OP_A_IMM
  } op_a_sel_e;

  typedef enum logic {
    OP_B_REG_B, OP_B_IMM
  } op_b_sel_e;

  typedef enum logic [2:0] {
    IMM_B_I, IMM_B_S, IMM_B_B, IMM_B_U, IMM_B_J, IMM_B_INCR_PC, IMM_B_INCR_ADDR
  } imm_b_sel_e;

  typedef enum logic {
    RF_WD_EX, RF_WD_LSU
  } rf_wd_sel_e;

endpackage

//--- source/id_decoder.sv
`timescale 1ns/1ps

module id_decoder import id_pkg::*; (
  input  logic [XLEN-1:0]       instr_rdata_i,
  output logic [XLEN-1:0]       imm_i_o,
  output logic [XLEN-1:0]       imm_s_o,
  output logic [XLEN-1:0]       imm_b_o,
  output logic [XLEN-1:0]       imm_u_o,
  output logic [XLEN-1:0]       imm_j_o,
  output logic [REG_ADDR_W-1:0] raddr_a_o,
  output logic [REG_ADDR_W-1:0] raddr_b_o,
  output logic [REG_ADDR_W-1:0] waddr_o,
  output op_a_sel_e             alu_op_a_sel_o,
  output op_b_sel_e             alu_op_b_sel_o,
  output imm_b_sel_e            imm_b_sel_o,
  output alu_op_e               alu_operator_o,
  output rf_wd_sel_e            rf_wd_sel_o,
  output logic                  regfile_we_o,
  output logic                  data_req_o,
  output logic                  data_we_o,
  output logic [1:0]            data_type_o,
  output logic                  data_sign_ext_o,
  output logic                  branch_o,
  output logic                  jump_o,
  output logic                  illegal_o
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [31:0] instr;

  assign instr  = instr_rdata_i;
  assign opcode = instr[6:0];
  assign funct3 = instr[14:12];
  assign funct7 = instr[31:25];

  assign raddr_a_o = instr[19:15];
  assign raddr_b_o = instr[24:20];
  assign waddr_o   = instr[11:7];

  // Sign-extended immediates of each format
  assign imm_i_o = {{20{instr[31]}}, instr[31:20]};
  assign imm_s_o = {{20{instr[31]}}, instr[31:25], instr[11:7]};
  assign imm_b_o = {{19{instr[31]}}, instr[31], instr[7], instr[30:25], instr[11:8], 1'b0};
  assign imm_u_o = {instr[31:12], 12'b0};
  assign imm_j_o = {{11{instr[31]}}, instr[31], instr[19:12], instr[20], instr[30:21], 1'b0};

  always_comb begin
    alu_op_a_sel_o  = OP_A_REG_A;
    alu_op_b_sel_o  = OP_B_IMM;
    imm_b_sel_o     = IMM_B_I;
    alu_operator_o  = ALU_ADD;
    rf_wd_sel_o     = RF_WD_EX;
    regfile_we_o    = 1'b0;
    data_req_o      = 1'b0;
    data_we_o       = 1'b0;
    data_type_o     = 2'b00;
    data_sign_ext_o = 1'b0;
    branch_o        = 1'b0;
    jump_o          = 1'b0;
    illegal_o       = 1'b0;

    case (opcode)
      OPCODE_OP, OPCODE_OP_IMM: begin
        regfile_we_o = 1'b1;
        if (opcode == OPCODE_OP) begin
          alu_op_b_sel_o = OP_B_REG_B;
        end
        case (funct3)
          3'b000: alu_operator_o = (opcode == OPCODE_OP && funct7[5]) ? ALU_SUB : ALU_ADD;
          3'b001: alu_operator_o = ALU_SLL;
          3'b010: alu_operator_o = ALU_SLT;
          3'b011: alu_operator_o = ALU_SLTU;
          3'b100: alu_operator_o = ALU_XOR;
          3'b101: alu_operator_o = funct7[5] ? ALU_SRA : ALU_SRL;
          3'b110: alu_operator_o = ALU_OR;
          default: alu_operator_o = ALU_AND;
        endcase
        // funct7 only carries information for OP and the immediate shifts
        if ((opcode == OPCODE_OP || funct3 ==? 3'b?01) &&
            funct7 != 7'h00 && !(funct7 == 7'h20 && funct3 ==? 3'b?0?)) begin
          illegal_o = 1'b1;
        end
        if (opcode == OPCODE_OP && funct7 == 7'h20 && funct3 != 3'b000 && funct3 != 3'b101) begin
          illegal_o = 1'b1;
        end
        if (opcode == OPCODE_OP_IMM && funct3 == 3'b001 && funct7 != 7'h00) begin
          illegal_o = 1'b1;
        end
      end
      OPCODE_LUI, OPCODE_AUIPC: begin
        alu_op_a_sel_o = (opcode == OPCODE_LUI) ? OP_A_IMM : OP_A_CURRPC;
        imm_b_sel_o    = IMM_B_U;
        regfile_we_o   = 1'b1;
      end
      OPCODE_LOAD: begin
        data_req_o      = 1'b1;
        rf_wd_sel_o     = RF_WD_LSU;
        regfile_we_o    = 1'b1;
        data_sign_ext_o = ~funct3[2];
        // Type encoding: 00 word, 01 half, 10 byte
        case (funct3)
          3'b000, 3'b100: data_type_o = 2'b10;
          3'b001, 3'b101: data_type_o = 2'b01;
          3'b010:         data_type_o = 2'b00;
          default:        illegal_o   = 1'b1;
        endcase
      end
      OPCODE_STORE: begin
        data_req_o  = 1'b1;
        data_we_o   = 1'b1;
        imm_b_sel_o = IMM_B_S;
        case (funct3)
          3'b000:  data_type_o = 2'b10;
          3'b001:  data_type_o = 2'b01;
          3'b010:  data_type_o = 2'b00;
          default: illegal_o   = 1'b1;
        endcase
      end
      OPCODE_BRANCH: begin
        branch_o       = 1'b1;
        alu_op_b_sel_o = OP_B_REG_B;
        imm_b_sel_o    = IMM_B_B;
        case (funct3)
          3'b000:  alu_operator_o = ALU_EQ;
          3'b001:  alu_operator_o = ALU_NE;
          3'b100:  alu_operator_o = ALU_LT;
          3'b101:  alu_operator_o = ALU_GE;
          3'b110:  alu_operator_o = ALU_LTU;
          3'b111:  alu_operator_o = ALU_GEU;
          default: illegal_o      = 1'b1;
        endcase
      end
      OPCODE_JAL, OPCODE_JALR: begin
        // Link address pc + 4 goes through the ALU
        jump_o         = 1'b1;
        alu_op_a_sel_o = OP_A_CURRPC;
        imm_b_sel_o    = IMM_B_INCR_PC;
        regfile_we_o   = 1'b1;
        if (opcode == OPCODE_JALR && funct3 != 3'b000) begin
          illegal_o = 1'b1;
        end
      end
      default: illegal_o = 1'b1;
    endcase

    if (illegal_o) begin
      regfile_we_o = 1'b0;
      data_req_o   = 1'b0;
      data_we_o    = 1'b0;
      branch_o     = 1'b0;
      jump_o       = 1'b0;
    end
  end

endmodule

//--- source/id_register_file.sv
`timescale 1ns/1ps

module id_register_file import id_pkg::*; #(
  parameter int unsigned NUM_REGS = id_pkg::NUM_REGS
) (
  input  logic                  clk_i,
  input  logic                  rst_ni,
  input  logic [REG_ADDR_W-1:0] raddr_a_i,
  input  logic [REG_ADDR_W-1:0] raddr_b_i,
  input  logic [REG_ADDR_W-1:0] waddr_i,
  input  logic [XLEN-1:0]       wdata_i,
  input  logic                  we_i,
  output logic [XLEN-1:0]       rdata_a_o,
  output logic [XLEN-1:0]       rdata_b_o
);

  logic [XLEN-1:0] regs_q [NUM_REGS];

  // Entry zero is cleared at reset and never written
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs_q[i] <= '0;
      end
    end else if (we_i && waddr_i != '0 && waddr_i < NUM_REGS) begin
      regs_q[waddr_i] <= wdata_i;
    end
  end

  // Combinational read, addresses beyond the array read zero
  assign rdata_a_o = (raddr_a_i < NUM_REGS) ? regs_q[raddr_a_i] : '0;
  assign rdata_b_o = (raddr_b_i < NUM_REGS) ? regs_q[raddr_b_i] : '0;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    we_i |-> waddr_i < NUM_REGS)
    else $error("Register write to x%0d beyond %0d entries", waddr_i, NUM_REGS);

endmodule

//--- source/id_operand_mux.sv
`timescale 1ns/1ps

module id_operand_mux import id_pkg::*; (
  input  op_a_sel_e       alu_op_a_sel_i,
  input  op_b_sel_e       alu_op_b_sel_i,
  input  imm_b_sel_e      imm_b_sel_i,
  input  logic [XLEN-1:0] imm_i_i,
  input  logic [XLEN-1:0] imm_s_i,
  input  logic [XLEN-1:0] imm_b_i,
  input  logic [XLEN-1:0] imm_u_i,
  input  logic [XLEN-1:0] imm_j_i,
  input  logic [XLEN-1:0] rdata_a_i,
  input  logic [XLEN-1:0] rdata_b_i,
  input  logic [XLEN-1:0] pc_id_i,
  input  logic [XLEN-1:0] lsu_addr_last_i,
  input  logic            lsu_addr_incr_req_i,
  output logic [XLEN-1:0] alu_operand_a_o,
  output logic [XLEN-1:0] alu_operand_b_o
);

  op_a_sel_e       op_a_sel;
  op_b_sel_e       op_b_sel;
  imm_b_sel_e      imm_sel;
  logic [XLEN-1:0] imm;

  // Second half of a misaligned access computes last address + 4
  assign op_a_sel = lsu_addr_incr_req_i ? OP_A_FWD        : alu_op_a_sel_i;
  assign op_b_sel = lsu_addr_incr_req_i ? OP_B_IMM        : alu_op_b_sel_i;
  assign imm_sel  = lsu_addr_incr_req_i ? IMM_B_INCR_ADDR : imm_b_sel_i;

  always_comb begin
    case (imm_sel)
      IMM_B_I:                        imm = imm_i_i;
      IMM_B_S:                        imm = imm_s_i;
      IMM_B_B:                        imm = imm_b_i;
      IMM_B_U:                        imm = imm_u_i;
      IMM_B_J:                        imm = imm_j_i;
      IMM_B_INCR_PC, IMM_B_INCR_ADDR: imm = ADDR_INCR;
      default:                        imm = '0;
    endcase
  end

  always_comb begin
    case (op_a_sel)
      OP_A_REG_A:  alu_operand_a_o = rdata_a_i;
      OP_A_FWD:    alu_operand_a_o = lsu_addr_last_i;
      OP_A_CURRPC: alu_operand_a_o = pc_id_i;
      default:     alu_operand_a_o = '0;
    endcase
  end

  assign alu_operand_b_o = (op_b_sel == OP_B_IMM) ? imm : rdata_b_i;

endmodule

//--- source/id_multicycle_fsm.sv
`timescale 1ns/1ps

module id_multicycle_fsm import id_pkg::*; (
  input  logic clk_i,
  input  logic rst_ni,
  input  logic instr_new_i,
  input  logic data_req_i,
  input  logic branch_i,
  input  logic jump_i,
  input  logic illegal_i,
  input  logic regfile_we_dec_i,
  input  logic branch_decision_i,
  input  logic ex_valid_i,
  input  logic lsu_valid_i,
  output logic regfile_we_o,
  output logic data_req_o,
  output logic id_ready_o,
  output logic pc_set_o,
  output logic instr_ret_o
);

  typedef enum logic {IDLE, WAIT_MULTICYCLE} id_fsm_e;

  id_fsm_e state_q, state_d;
  logic    done_q, done_d;
  logic    branch_set_q, branch_set_d;
  logic    regfile_we_wb;
  logic    stall;
  logic    executing;
  logic    completion;
  logic    taken_branch;

  assign taken_branch = branch_i & branch_decision_i;
  // Memory ops end on the LSU strobe, everything else on EX
  assign completion   = data_req_i ? lsu_valid_i : ex_valid_i;

  always_comb begin
    state_d       = state_q;
    done_d        = done_q;
    branch_set_d  = 1'b0;
    regfile_we_wb = 1'b0;
    stall         = 1'b0;
    instr_ret_o   = 1'b0;
    case (state_q)
      IDLE: begin
        if (instr_new_i && !illegal_i) begin
          if (data_req_i || jump_i || taken_branch) begin
            state_d      = WAIT_MULTICYCLE;
            done_d       = 1'b0;
            stall        = 1'b1;
            branch_set_d = jump_i | taken_branch;
          end else begin
            done_d      = 1'b1;
            instr_ret_o = 1'b1;
          end
        end
      end
      WAIT_MULTICYCLE: begin
        if (completion) begin
          state_d       = IDLE;
          done_d        = 1'b1;
          regfile_we_wb = regfile_we_dec_i;
          instr_ret_o   = 1'b1;
        end else begin
          stall = 1'b1;
        end
      end
      default: state_d = IDLE;
    endcase
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q      <= IDLE;
      done_q       <= 1'b1;
      branch_set_q <= 1'b0;
    end else begin
      state_q      <= state_d;
      done_q       <= done_d;
      branch_set_q <= branch_set_d;
    end
  end

  // Loads and jumps write at completion, the rest while new
  assign executing    = instr_new_i | ~done_q;
  assign regfile_we_o = executing & ~illegal_i &
                        ((data_req_i | jump_i) ? regfile_we_wb : regfile_we_dec_i);
  assign data_req_o   = instr_new_i & data_req_i & (state_q == IDLE);
  assign id_ready_o   = ~stall;
  assign pc_set_o     = branch_set_q;

  assert property (@(posedge clk_i) disable iff (!rst_ni)
    (instr_new_i && branch_i) |-> !$isunknown(branch_decision_i))
    else $error("Branch decision unknown for a new branch");

endmodule

//--- source/id_stage.sv
`timescale 1ns/1ps

module id_stage import id_pkg::*; (
  input  logic            clk_i,
  input  logic            rst_ni,
  input  logic            instr_valid_i,
  input  logic            instr_new_i,
  input  logic [XLEN-1:0] instr_rdata_i,
  input  logic [XLEN-1:0] pc_id_i,
  input  logic            branch_decision_i,
  input  logic            ex_valid_i,
  input  logic            lsu_valid_i,
  input  logic            lsu_addr_incr_req_i,
  input  logic [XLEN-1:0] lsu_addr_last_i,
  input  logic [XLEN-1:0] regfile_wdata_ex_i,
  input  logic [XLEN-1:0] regfile_wdata_lsu_i,
  output alu_op_e         alu_operator_o,
  output logic [XLEN-1:0] alu_operand_a_o,
  output logic [XLEN-1:0] alu_operand_b_o,
  output logic            data_req_o,
  output logic            data_we_o,
  output logic [1:0]      data_type_o,
  output logic            data_sign_ext_o,
  output logic [XLEN-1:0] data_wdata_o,
  output logic            illegal_insn_o,
  output logic            id_ready_o,
  output logic            pc_set_o,
  output logic            instr_ret_o
);

  logic [XLEN-1:0]       imm_i, imm_s, imm_b, imm_u, imm_j;
  logic [REG_ADDR_W-1:0] raddr_a, raddr_b, waddr;
  logic [XLEN-1:0]       rdata_a, rdata_b, regfile_wdata;
  op_a_sel_e             alu_op_a_sel;
  op_b_sel_e             alu_op_b_sel;
  imm_b_sel_e            imm_b_sel;
  rf_wd_sel_e            rf_wd_sel;
  logic                  regfile_we_dec, regfile_we;
  logic                  data_req_dec, branch_in_dec, jump_in_dec;

  //////////////////////////////////////////////////////////////////////////
  // Decode and operands
  //////////////////////////////////////////////////////////////////////////

  id_decoder u_decoder (
    .instr_rdata_i  (instr_rdata_i),
    .imm_i_o        (imm_i),
    .imm_s_o        (imm_s),
    .imm_b_o        (imm_b),
    .imm_u_o        (imm_u),
    .imm_j_o        (imm_j),
    .raddr_a_o      (raddr_a),
    .raddr_b_o      (raddr_b),
    .waddr_o        (waddr),
    .alu_op_a_sel_o (alu_op_a_sel),
    .alu_op_b_sel_o (alu_op_b_sel),
    .imm_b_sel_o    (imm_b_sel),
    .alu_operator_o (alu_operator_o),
    .rf_wd_sel_o    (rf_wd_sel),
    .regfile_we_o   (regfile_we_dec),
    .data_req_o     (data_req_dec),
    .data_we_o      (data_we_o),
    .data_type_o    (data_type_o),
    .data_sign_ext_o(data_sign_ext_o),
    .branch_o       (branch_in_dec),
    .jump_o         (jump_in_dec),
    .illegal_o      (illegal_insn_o)
  );

  id_operand_mux u_operand_mux (
    .alu_op_a_sel_i     (alu_op_a_sel),
    .alu_op_b_sel_i     (alu_op_b_sel),
    .imm_b_sel_i        (imm_b_sel),
    .imm_i_i            (imm_i),
    .imm_s_i            (imm_s),
    .imm_b_i            (imm_b),
    .imm_u_i            (imm_u),
    .imm_j_i            (imm_j),
    .rdata_a_i          (rdata_a),
    .rdata_b_i          (rdata_b),
    .pc_id_i            (pc_id_i),
    .lsu_addr_last_i    (lsu_addr_last_i),
    .lsu_addr_incr_req_i(lsu_addr_incr_req_i),
    .alu_operand_a_o    (alu_operand_a_o),
    .alu_operand_b_o    (alu_operand_b_o)
  );

  //////////////////////////////////////////////////////////////////////////
  // Register file and write-back
  //////////////////////////////////////////////////////////////////////////

  assign regfile_wdata = (rf_wd_sel == RF_WD_LSU) ? regfile_wdata_lsu_i : regfile_wdata_ex_i;
  // Store data is rs2 straight from the register file
  assign data_wdata_o  = rdata_b;

  id_register_file #(.NUM_REGS(NUM_REGS)) u_register_file (
    .clk_i    (clk_i),
    .rst_ni   (rst_ni),
    .raddr_a_i(raddr_a),
    .raddr_b_i(raddr_b),
    .waddr_i  (waddr),
    .wdata_i  (regfile_wdata),
    .we_i     (regfile_we),
    .rdata_a_o(rdata_a),
    .rdata_b_o(rdata_b)
  );

  id_multicycle_fsm u_multicycle_fsm (
    .clk_i            (clk_i),
    .rst_ni           (rst_ni),
    .instr_new_i      (instr_new_i),
    .data_req_i       (data_req_dec),
    .branch_i         (branch_in_dec),
    .jump_i           (jump_in_dec),
    .illegal_i        (illegal_insn_o),
    .regfile_we_dec_i (regfile_we_dec),
    .branch_decision_i(branch_decision_i),
    .ex_valid_i       (ex_valid_i),
    .lsu_valid_i      (lsu_valid_i),
    .regfile_we_o     (regfile_we),
    .data_req_o       (data_req_o),
    .id_ready_o       (id_ready_o),
    .pc_set_o         (pc_set_o),
    .instr_ret_o      (instr_ret_o)
  );

  // IF hands over a fully defined word while valid
  assert property (@(posedge clk_i) disable iff (!rst_ni)
    instr_valid_i |-> !$isunknown(instr_rdata_i))
    else $error("Valid instruction holds unknown bits");

endmodule

//--- include/id_stage_vectors.svh
  // Columns: instruction, pc (last LSU address when the misaligned request is set),
  // branch decision, misaligned request, operator, operand A source and value,
  // operand B source and value, completion kind, write-back source,
  // {data_we, data_type, data_sign_ext}
  localparam int NUM_VECTORS = 21;

  vector_t vectors [NUM_VECTORS];

  function automatic void load_vectors();
    // ALU ops, x0 writes, LUI and AUIPC
    vectors[0]  = '{32'hFFB00093, 32'h0, 1'b0, 1'b0,
                    ALU_ADD, SRC_LIT, 32'h0, SRC_LIT, 32'hFFFFFFFB, DONE_NOW, WR_EX, 4'b0000};
    vectors[1]  = '{32'h12308113, 32'h0, 1'b0, 1'b0,
                    ALU_ADD, SRC_RS1, 32'h0, SRC_LIT, 32'h00000123, DONE_NOW, WR_EX, 4'b0000};
    vectors[2]  = '{32'h002081B3, 32'h0, 1'b0, 1'b0,
                    ALU_ADD, SRC_RS1, 32'h0, SRC_RS2, 32'h0, DONE_NOW, WR_EX, 4'b0000};
    vectors[3]  = '{32'h40118233, 32'h0, 1'b0, 1'b0,
                    ALU_SUB, SRC_RS1, 32'h0, SRC_RS2, 32'h0, DONE_NOW, WR_EX, 4'b0000};
    vectors[4]  = '{32'h00108013, 32'h0, 1'b0, 1'b0,
                    ALU_ADD, SRC_RS1, 32'h0, SRC_LIT, 32'h00000001, DONE_NOW, WR_EX, 4'b0000};
    vectors[5]  = '{32'h000002B3, 32'h0, 1'b0, 1'b0,
                    ALU_ADD, SRC_LIT, 32'h0, SRC_LIT, 32'h0, DONE_NOW, WR_EX, 4'b0000};
    vectors[6]  = '{32'hABCDE337, 32'h0, 1'b0, 1'b0,
                    ALU_ADD, SRC_LIT, 32'h0, SRC_LIT, 32'hABCDE000, DONE_NOW, WR_EX, 4'b0000};
    vectors[7]  = '{32'h00001697, 32'h100, 1'b0, 1'b0,
                    ALU_ADD, SRC_LIT, 32'h100, SRC_LIT, 32'h00001000, DONE_NOW, WR_EX, 4'b0000};
    // Stores and loads, each load read back by a later instruction
    vectors[8]  = '{32'h00312423, 32'h0, 1'b0, 1'b0,
                    ALU_ADD, SRC_RS1, 32'h0, SRC_LIT, 32'h00000008, DONE_LSU, WR_NONE, 4'b1000};
    vectors[9]  = '{32'h0040A383, 32'h0, 1'b0, 1'b0,
                    ALU_ADD, SRC_RS1, 32'h0, SRC_LIT, 32'h00000004, DONE_LSU, WR_LSU, 4'b0001};
    vectors[10] = '{32'hFFF3C403, 32'h0, 1'b0, 1'b0,
                    ALU_ADD, SRC_RS1, 32'h0, SRC_LIT, 32'hFFFFFFFF, DONE_LSU, WR_LSU, 4'b0100};
    vectors[11] = '{32'h00801023, 32'h0, 1'b0, 1'b0,
                    ALU_ADD, SRC_LIT, 32'h0, SRC_LIT, 32'h0, DONE_LSU, WR_NONE, 4'b1010};
    // Taken BEQ, untaken BLTU, taken BNE
    vectors[12] = '{32'h00208863, 32'h0, 1'b1, 1'b0,
                    ALU_EQ, SRC_RS1, 32'h0, SRC_RS2, 32'h0, DONE_EX, WR_NONE, 4'b0000};
    vectors[13] = '{32'hFE41ECE3, 32'h0, 1'b0, 1'b0,
                    ALU_LTU, SRC_RS1, 32'h0, SRC_RS2, 32'h0, DONE_NOW, WR_NONE, 4'b0000};
    vectors[14] = '{32'h00011863, 32'h0, 1'b1, 1'b0,
                    ALU_NE, SRC_RS1, 32'h0, SRC_RS2, 32'h0, DONE_EX, WR_NONE, 4'b0000};
    // JAL link into x9, then a read of x9
    vectors[15] = '{32'h100004EF, 32'h200, 1'b0, 1'b0,
                    ALU_ADD, SRC_LIT, 32'h200, SRC_LIT, 32'h00000004, DONE_EX, WR_EX, 4'b0000};
    vectors[16] = '{32'h00048513, 32'h0, 1'b0, 1'b0,
                    ALU_ADD, SRC_RS1, 32'h0, SRC_LIT, 32'h0, DONE_NOW, WR_EX, 4'b0000};
    // Misaligned second half, then two illegal words aimed at x10
    vectors[17] = '{32'h0020A583, 32'h1003, 1'b0, 1'b1,
                    ALU_ADD, SRC_LIT, 32'h1003, SRC_LIT, 32'h00000004, DONE_LSU, WR_LSU, 4'b0001};
    vectors[18] = '{32'h0000057F, 32'h0, 1'b0, 1'b0,
                    ALU_ADD, SRC_LIT, 32'h0, SRC_LIT, 32'h0, DONE_NONE, WR_NONE, 4'b0000};
    vectors[19] = '{32'h02208533, 32'h0, 1'b0, 1'b0,
                    ALU_ADD, SRC_LIT, 32'h0, SRC_LIT, 32'h0, DONE_NONE, WR_NONE, 4'b0000};
    vectors[20] = '{32'h00050613, 32'h0, 1'b0, 1'b0,
                    ALU_ADD, SRC_RS1, 32'h0, SRC_LIT, 32'h0, DONE_NOW, WR_EX, 4'b0000};
  endfunction

//--- bench/id_stage_tb.sv
`timescale 1ns/1ps

module id_stage_tb import id_pkg::*; ();

  localparam int TIMEOUT_CYCLES = 20;

  // Operand sources, completion kinds and write-back sources of the table
  localparam logic [1:0] SRC_LIT   = 2'd0;
  localparam logic [1:0] SRC_RS1   = 2'd1;
  localparam logic [1:0] SRC_RS2   = 2'd2;
  localparam logic [1:0] DONE_NOW  = 2'd0;
  localparam logic [1:0] DONE_LSU  = 2'd1;
  localparam logic [1:0] DONE_EX   = 2'd2;
  localparam logic [1:0] DONE_NONE = 2'd3;
  localparam logic [1:0] WR_NONE   = 2'd0;
  localparam logic [1:0] WR_EX     = 2'd1;
  localparam logic [1:0] WR_LSU    = 2'd2;

  typedef struct packed {
    logic [XLEN-1:0] instr;
    logic [XLEN-1:0] addr;
    logic            bdec;
    logic            incr;
    alu_op_e         op;
    logic [1:0]      a_src;
    logic [XLEN-1:0] lit_a;
    logic [1:0]      b_src;
    logic [XLEN-1:0] lit_b;
    logic [1:0]      done;
    logic [1:0]      wr;
    logic [3:0]      mem;
  } vector_t;

  logic            clk = 1'b0;
  logic            rst_n;
  logic            instr_valid;
  logic            instr_new;
  logic [XLEN-1:0] instr_rdata;
  logic [XLEN-1:0] pc_id;
  logic            branch_decision;
  logic            ex_valid;
  logic            lsu_valid;
  logic            lsu_addr_incr_req;
  logic [XLEN-1:0] lsu_addr_last;
  logic [XLEN-1:0] wdata_ex;
  logic [XLEN-1:0] wdata_lsu;
  alu_op_e         alu_operator;
  logic [XLEN-1:0] operand_a;
  logic [XLEN-1:0] operand_b;
  logic            data_req;
  logic            data_we;
  logic [1:0]      data_type;
  logic            data_sign_ext;
  logic [XLEN-1:0] data_wdata;
  logic            illegal_insn;
  logic            id_ready;
  logic            pc_set;
  logic            instr_ret;

  // Reference register contents, x0 never written
  logic [XLEN-1:0] reg_model [NUM_REGS];
  integer          seed;
  int              errors;
  int              checks;
  int              cur_vec;
  logic            timed_out;

  `include "id_stage_vectors.svh"

  always #4 clk = ~clk;

  id_stage uut (
    .clk_i              (clk),
    .rst_ni             (rst_n),
    .instr_valid_i      (instr_valid),
    .instr_new_i        (instr_new),
    .instr_rdata_i      (instr_rdata),
    .pc_id_i            (pc_id),
    .branch_decision_i  (branch_decision),
    .ex_valid_i         (ex_valid),
    .lsu_valid_i        (lsu_valid),
    .lsu_addr_incr_req_i(lsu_addr_incr_req),
    .lsu_addr_last_i    (lsu_addr_last),
    .regfile_wdata_ex_i (wdata_ex),
    .regfile_wdata_lsu_i(wdata_lsu),
    .alu_operator_o     (alu_operator),
    .alu_operand_a_o    (operand_a),
    .alu_operand_b_o    (operand_b),
    .data_req_o         (data_req),
    .data_we_o          (data_we),
    .data_type_o        (data_type),
    .data_sign_ext_o    (data_sign_ext),
    .data_wdata_o       (data_wdata),
    .illegal_insn_o     (illegal_insn),
    .id_ready_o         (id_ready),
    .pc_set_o           (pc_set),
    .instr_ret_o        (instr_ret)
  );

  task automatic check_value(input string name, input logic [XLEN-1:0] exp,
                             input logic [XLEN-1:0] act);
    checks++;
    assert (act === exp)
      else begin
        errors++;
        $display("Error: %s expected %h got %h (vector %0d)", name, exp, act, cur_vec);
      end
  endtask

  task automatic check_bit(input string name, input logic exp, input logic act);
    checks++;
    assert (act === exp)
      else begin
        errors++;
        $display("Error: %s expected %h got %h (vector %0d)", name, exp, act, cur_vec);
      end
  endtask

  function automatic logic [XLEN-1:0] expected_operand(input logic [1:0] src,
      input logic [XLEN-1:0] lit, input logic [XLEN-1:0] instr);
    case (src)
      SRC_RS1: return reg_model[instr[19:15]];
      SRC_RS2: return reg_model[instr[24:20]];
      default: return lit;
    endcase
  endfunction

  task automatic run_vector(input int idx);
    vector_t         v;
    logic            multi;
    logic            retired;
    logic [4:0]      rd;
    int              delay;
    int              cnt;
    v       = vectors[idx];
    cur_vec = idx;
    multi   = (v.done == DONE_LSU) || (v.done == DONE_EX);
    rd      = v.instr[11:7];
    @(negedge clk);
    instr_valid       = 1'b1;
    instr_new         = 1'b1;
    instr_rdata       = v.instr;
    // Address not under test gets its complement
    pc_id             = v.incr ? ~v.addr : v.addr;
    lsu_addr_last     = v.incr ? v.addr : ~v.addr;
    branch_decision   = v.bdec;
    lsu_addr_incr_req = v.incr;
    ex_valid          = 1'b0;
    lsu_valid         = 1'b0;
    wdata_ex          = $random(seed);
    wdata_lsu         = $random(seed);
    #1;
    // Decode cycle
    check_bit("illegal_insn_o", v.done == DONE_NONE, illegal_insn);
    if (v.done != DONE_NONE) begin
      check_value("alu_operator_o", 32'(v.op), 32'(alu_operator));
      check_value("alu_operand_a_o", expected_operand(v.a_src, v.lit_a, v.instr), operand_a);
      check_value("alu_operand_b_o", expected_operand(v.b_src, v.lit_b, v.instr), operand_b);
    end
    check_bit("id_ready_o", !multi, id_ready);
    check_bit("instr_ret_o", v.done == DONE_NOW, instr_ret);
    check_bit("pc_set_o", 1'b0, pc_set);
    check_bit("data_req_o", v.done == DONE_LSU, data_req);
    if (v.done == DONE_LSU) begin
      check_bit("data_we_o", v.mem[3], data_we);
      check_value("data_type_o", {30'b0, v.mem[2:1]}, {30'b0, data_type});
      check_bit("data_sign_ext_o", v.mem[0], data_sign_ext);
      if (v.mem[3]) begin
        check_value("data_wdata_o", reg_model[v.instr[24:20]], data_wdata);
      end
    end
    if (multi) begin
      // Completion strobe arrives after a random delay
      delay   = $unsigned($random(seed)) % 4;
      retired = 1'b0;
      cnt     = 0;
      while (!retired && cnt < TIMEOUT_CYCLES) begin
        @(negedge clk);
        instr_new = 1'b0;
        lsu_valid = (v.done == DONE_LSU) && (cnt == delay);
        ex_valid  = (v.done == DONE_EX) && (cnt == delay);
        #1;
        retired = instr_ret;
        check_bit("pc_set_o", (cnt == 0) && (v.done == DONE_EX), pc_set);
        check_bit("id_ready_o", retired, id_ready);
        check_bit("data_req_o", 1'b0, data_req);
        if (retired) begin
          check_value("instr_ret_o cycle", delay, cnt);
        end
        cnt++;
      end
      if (!retired) begin
        errors++;
        timed_out = 1'b1;
        $display("Timeout: vector %0d did not retire within %0d cycles", idx, TIMEOUT_CYCLES);
      end
    end
    if (rd != 5'd0 && v.wr == WR_EX) begin
      reg_model[rd] = wdata_ex;
    end else if (rd != 5'd0 && v.wr == WR_LSU) begin
      reg_model[rd] = wdata_lsu;
    end
  endtask

  initial begin
    seed              = 29668;
    errors            = 0;
    checks            = 0;
    cur_vec           = -1;
    timed_out         = 1'b0;
    rst_n             = 1'b0;
    instr_valid       = 1'b0;
    instr_new         = 1'b0;
    instr_rdata       = '0;
    pc_id             = '0;
    branch_decision   = 1'b0;
    ex_valid          = 1'b0;
    lsu_valid         = 1'b0;
    lsu_addr_incr_req = 1'b0;
    lsu_addr_last     = '0;
    wdata_ex          = '0;
    wdata_lsu         = '0;
    for (int r = 0; r < NUM_REGS; r++) begin
      reg_model[r] = '0;
    end
    load_vectors();
    repeat (8) @(posedge clk);
    @(negedge clk);
    rst_n = 1'b1;
    #1;
    // Idle state after reset
    check_bit("id_ready_o", 1'b1, id_ready);
    check_bit("pc_set_o", 1'b0, pc_set);
    check_bit("instr_ret_o", 1'b0, instr_ret);
    check_bit("data_req_o", 1'b0, data_req);
    for (int i = 0; i < NUM_VECTORS && !timed_out; i++) begin
      run_vector(i);
    end
    $display("Checks: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("Regression passed");
    end else begin
      $display("Regression failed");
    end
    $finish;
  end

endmodule

//--- sources.f
+incdir+include
source/id_pkg.sv
source/id_decoder.sv
source/id_register_file.sv
source/id_operand_mux.sv
source/id_multicycle_fsm.sv
source/id_stage.sv
bench/id_stage_tb.sv

//--- run.sh
#!/bin/sh
# Build the ID stage testbench with Verilator, run it and look for the pass line
verilator --binary --assert -Wno-fatal --top-module id_stage_tb -f sources.f -o id_stage_sim \
  || { echo "run.sh: build FAIL"; exit 1; }
./obj_dir/id_stage_sim | tee /dev/stderr | grep -x "Regression passed" > /dev/null \
  && echo "run.sh: PASS" \
  || { echo "run.sh: FAIL"; exit 1; }
